// File: common/dcache_pkg.sv
// Data cache shared types

package dcache_pkg;

    //////////////////////////////////////////////////////////////////////
    // Default geometry
    //////////////////////////////////////////////////////////////////////

    // Number of ways
    localparam int DEF_WAYS = 2;

    // Lines per way
    localparam int DEF_LINES = 64;

    // Words per line
    localparam int DEF_LINE_WORDS = 4;

    //////////////////////////////////////////////////////////////////////
    // Plain vector types
    //////////////////////////////////////////////////////////////////////

    // Byte address
    typedef logic [31:0] addr_t;

    // Word address as seen by memory
    typedef logic [29:0] waddr_t;

    // One data word
    typedef logic [31:0] word_t;

    // One enable per byte of a word
    typedef logic [3:0] be_t;

    // Burst length, words minus one
    typedef logic [4:0] rlen_t;

    //////////////////////////////////////////////////////////////////////
    // Request structs
    //////////////////////////////////////////////////////////////////////

    // Load/store request from the core side
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        be_t   be;
        logic  we;
    } ls_req_t;

    // Request towards memory
    // Reads ask for a whole line starting at word 0
    typedef struct packed {
        waddr_t addr;
        word_t  wdata;
        be_t    wbe;
        logic   rnw;
        rlen_t  rlen;
    } mem_req_t;

endpackage

// File: dcache_top.f
common/dcache_pkg.sv
tag_bank/dcache_tag_bank.sv
logic/dcache_data_bank.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
testbench/tb_clock.sv
testbench/dcache_checker.sv
testbench/dcache_tb.sv

// File: logic/dcache_ctrl.sv
// Data cache controller

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int WAYS       = DEF_WAYS,
    parameter int LINES      = DEF_LINES,
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      new_request,
    input  ls_req_t   req,
    input  logic      ack,
    input  logic      rvalid,
    input  word_t     rdata,
    input  logic      hit,
    input  logic [WAYS-1:0] hit_way,
    input  logic      resetting,
    input  logic      snoop_write,
    input  logic      inv_match,
    input  word_t     hit_word,
    output logic      ready,
    output logic      data_valid,
    output word_t     data_out,
    output logic      mem_request,
    output mem_req_t  mem,
    output logic [$clog2(LINES)-1:0] lookup_line,
    output logic [30-$clog2(LINES)-$clog2(LINE_WORDS)-1:0] stage1_tag,
    output logic [$clog2(LINES)-1:0] stage1_line,
    output logic      fill_write,
    output logic [WAYS-1:0] fill_way,
    output logic      fill_valid,
    output logic      db_read_en,
    output logic [$clog2(LINES)+$clog2(LINE_WORDS)-1:0] db_read_addr,
    output logic      db_write_en,
    output logic [$clog2(LINES)+$clog2(LINE_WORDS)-1:0] db_write_addr,
    output logic [WAYS-1:0] db_write_way,
    output be_t       db_write_be,
    output word_t     db_write_data
);

    localparam int LINE_W = $clog2(LINES);
    localparam int OFF_W  = $clog2(LINE_WORDS);
    localparam int TAG_W  = 30 - LINE_W - OFF_W;

    typedef enum logic [1:0] {IDLE, LOOKUP, MEM_WAIT, FILLING} state_t;

    state_t          state;
    state_t          next_state;
    ls_req_t         stage1;
    logic            accept;
    logic            done;
    logic            request_sent;
    logic            fill_kill;
    logic [OFF_W-1:0] word_counter;
    logic [WAYS-1:0] repl_way;
    logic [WAYS-1:0] repl_next;
    logic            lookup_miss;
    logic            filling;

    assign accept      = new_request & ready;
    assign filling     = state == FILLING;
    assign lookup_miss = (state == LOOKUP) & (stage1.we | ~hit);

    //////////////////////////////////////////////////////////////////////
    // Stage 1 and state machine
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
        if (accept)
            stage1 <= req;
    end

    always_comb begin
        unique case (state)
            LOOKUP: begin
                if (~stage1.we & hit)
                    next_state = IDLE;
                else if (ack)
                    next_state = stage1.we ? IDLE : FILLING;
                else
                    next_state = MEM_WAIT;
            end
            MEM_WAIT: begin
                if (ack)
                    next_state = stage1.we ? IDLE : FILLING;
                else
                    next_state = MEM_WAIT;
            end
            FILLING: next_state = done ? IDLE : FILLING;
            default: next_state = IDLE;
        endcase
        // A new request can start in the cycle the old one finishes
        if (accept)
            next_state = LOOKUP;
    end

    always_comb begin
        unique case (state)
            LOOKUP:   done = stage1.we ? ack : hit;
            MEM_WAIT: done = stage1.we & ack;
            FILLING:  done = rvalid & (word_counter == OFF_W'(LINE_WORDS - 1));
            default:  done = 1'b0;
        endcase
    end

    assign ready = ~resetting & ~snoop_write & ((state == IDLE) | done)
                 & ~db_write_en & ~fill_write;

    //////////////////////////////////////////////////////////////////////
    // Memory side
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst | accept | done)
            request_sent <= 1'b0;
        else if (ack)
            request_sent <= 1'b1;
    end

    assign mem_request = (lookup_miss | (state == MEM_WAIT)) & ~request_sent;

    // Reads fetch the whole line from word 0
    assign mem = '{
        addr:  stage1.we ? stage1.addr[31:2] : {stage1.addr[31:2+OFF_W], OFF_W'(0)},
        wdata: stage1.wdata,
        wbe:   stage1.be,
        rnw:   ~stage1.we,
        rlen:  rlen_t'(LINE_WORDS - 1)
    };

    always_ff @(posedge clk) begin
        if (rst | accept)
            word_counter <= '0;
        else if (filling & rvalid)
            word_counter <= word_counter + 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // Tag fill
    //////////////////////////////////////////////////////////////////////

    // Write is held while a snoop clear owns the tag port
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_write <= 1'b0;
            fill_kill  <= 1'b0;
        end else begin
            fill_write <= (ack & ~stage1.we) | (fill_write & snoop_write);
            fill_kill  <= fill_write & snoop_write & (fill_kill | inv_match);
        end
    end

    assign fill_valid = ~inv_match & ~fill_kill;
    assign fill_way   = repl_way;

    // Rotating one-hot way choice
    always_comb begin
        for (int i = 0; i < WAYS; i++)
            repl_next[i] = repl_way[(i + WAYS - 1) % WAYS];
    end

    always_ff @(posedge clk) begin
        if (rst)
            repl_way <= WAYS'(1);
        else if (accept)
            repl_way <= repl_next;
    end

    assign lookup_line = req.addr[2+OFF_W +: LINE_W];
    assign stage1_tag  = stage1.addr[31 -: TAG_W];
    assign stage1_line = stage1.addr[2+OFF_W +: LINE_W];

    //////////////////////////////////////////////////////////////////////
    // Data bank and responses
    //////////////////////////////////////////////////////////////////////
    assign db_read_en   = accept;
    assign db_read_addr = req.addr[2 +: LINE_W+OFF_W];

    assign db_write_en   = ((state == LOOKUP) & stage1.we & hit) | (filling & rvalid);
    assign db_write_addr = {stage1_line, filling ? word_counter : stage1.addr[2 +: OFF_W]};
    assign db_write_way  = filling ? repl_way : hit_way;
    assign db_write_be   = filling ? '1 : stage1.be;
    assign db_write_data = filling ? rdata : stage1.wdata;

    assign data_valid = ((state == LOOKUP) & ~stage1.we & hit)
                      | (filling & rvalid & (word_counter == stage1.addr[2 +: OFF_W]));
    assign data_out   = (state == LOOKUP) ? hit_word : rdata;

endmodule

// File: logic/dcache_data_bank.sv
// Data cache word storage

module dcache_data_bank
    import dcache_pkg::*;
#(
    parameter int WAYS       = DEF_WAYS,
    parameter int LINES      = DEF_LINES,
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic                                             clk,
    input  logic                                             db_read_en,
    input  logic [$clog2(LINES)+$clog2(LINE_WORDS)-1:0]      db_read_addr,
    input  logic [WAYS-1:0]                                  hit_way,
    input  logic                                             db_write_en,
    input  logic [$clog2(LINES)+$clog2(LINE_WORDS)-1:0]      db_write_addr,
    input  logic [WAYS-1:0]                                  db_write_way,
    input  be_t                                              db_write_be,
    input  word_t                                            db_write_data,
    output word_t                                            hit_word
);

    localparam int DEPTH = LINES * LINE_WORDS;
    localparam int BYTES = $bits(be_t);

    // One byte column per way and byte lane
    logic [WAYS-1:0][BYTES-1:0][7:0] ram [DEPTH];
    logic [WAYS-1:0][BYTES-1:0][7:0] rd_words;

    //////////////////////////////////////////////////////////////////////
    // Write and registered read
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            for (int b = 0; b < BYTES; b++) begin
                if (db_write_en & db_write_way[w] & db_write_be[b])
                    ram[db_write_addr][w][b] <= db_write_data[8*b +: 8];
            end
        end
        if (db_read_en)
            rd_words <= ram[db_read_addr];
    end

    //////////////////////////////////////////////////////////////////////
    // Way select
    //////////////////////////////////////////////////////////////////////

    // hit_way is one-hot or zero, so an OR of the masked words is enough
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_way[w])
                hit_word = hit_word | rd_words[w];
        end
    end

endmodule

// File: logic/dcache_top.sv
// Data cache top level

module dcache_top
    import dcache_pkg::*;
#(
    parameter int WAYS       = DEF_WAYS,
    parameter int LINES      = DEF_LINES,
    parameter int LINE_WORDS = DEF_LINE_WORDS
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     new_request,
    input  ls_req_t  req,
    input  logic     ack,
    input  logic     rvalid,
    input  word_t    rdata,
    input  logic     inv,
    input  addr_t    inv_addr,
    output logic     ready,
    output logic     data_valid,
    output word_t    data_out,
    output logic     mem_request,
    output mem_req_t mem
);

    localparam int LINE_W = $clog2(LINES);
    localparam int OFF_W  = $clog2(LINE_WORDS);
    localparam int TAG_W  = 30 - LINE_W - OFF_W;

    //////////////////////////////////////////////////////////////////////
    // Internal nets
    //////////////////////////////////////////////////////////////////////

    // Tag bank
    logic [LINE_W-1:0] lookup_line;
    logic [TAG_W-1:0]  stage1_tag;
    logic [LINE_W-1:0] stage1_line;
    logic              fill_write;
    logic [WAYS-1:0]   fill_way;
    logic              fill_valid;
    logic              hit;
    logic [WAYS-1:0]   hit_way;
    logic              snoop_write;
    logic              resetting;
    logic              inv_match;

    // Data bank
    logic                    db_read_en;
    logic [LINE_W+OFF_W-1:0] db_read_addr;
    logic                    db_write_en;
    logic [LINE_W+OFF_W-1:0] db_write_addr;
    logic [WAYS-1:0]         db_write_way;
    be_t                     db_write_be;
    word_t                   db_write_data;
    word_t                   hit_word;

    //////////////////////////////////////////////////////////////////////
    // Blocks
    //////////////////////////////////////////////////////////////////////
    dcache_ctrl #(
        .WAYS       (WAYS),
        .LINES      (LINES),
        .LINE_WORDS (LINE_WORDS)
    ) ctrl_i (
        .clk, .rst, .new_request, .req, .ack, .rvalid, .rdata,
        .hit, .hit_way, .resetting, .snoop_write, .inv_match, .hit_word,
        .ready, .data_valid, .data_out, .mem_request, .mem,
        .lookup_line, .stage1_tag, .stage1_line,
        .fill_write, .fill_way, .fill_valid,
        .db_read_en, .db_read_addr, .db_write_en, .db_write_addr,
        .db_write_way, .db_write_be, .db_write_data
    );

    dcache_tag_bank #(
        .WAYS  (WAYS),
        .LINES (LINES),
        .TAG_W (TAG_W)
    ) tags_i (
        .clk, .rst, .lookup_line, .stage1_tag, .stage1_line,
        .fill_write, .fill_way, .fill_valid, .inv, .inv_addr,
        .hit, .hit_way, .snoop_write, .resetting, .inv_match
    );

    dcache_data_bank #(
        .WAYS       (WAYS),
        .LINES      (LINES),
        .LINE_WORDS (LINE_WORDS)
    ) data_i (
        .clk, .db_read_en, .db_read_addr, .hit_way,
        .db_write_en, .db_write_addr, .db_write_way,
        .db_write_be, .db_write_data, .hit_word
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the data cache simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module dcache_tb -f dcache_top.f -o dcache_sim

./obj_dir/dcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1

// File: tag_bank/dcache_tag_bank.sv
// Data cache tag bank

module dcache_tag_bank
    import dcache_pkg::*;
#(
    parameter int WAYS  = DEF_WAYS,
    parameter int LINES = DEF_LINES,
    parameter int TAG_W = 24
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [$clog2(LINES)-1:0] lookup_line,
    input  logic [TAG_W-1:0]         stage1_tag,
    input  logic [$clog2(LINES)-1:0] stage1_line,
    input  logic                     fill_write,
    input  logic [WAYS-1:0]          fill_way,
    input  logic                     fill_valid,
    input  logic                     inv,
    input  addr_t                    inv_addr,
    output logic                     hit,
    output logic [WAYS-1:0]          hit_way,
    output logic                     snoop_write,
    output logic                     resetting,
    output logic                     inv_match
);

    localparam int LINE_W = $clog2(LINES);

    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [LINE_W-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } entry_t;

    entry_t tags [WAYS][LINES];

    // Tag sits at the top of the address, line index right below it
    tag_t  inv_tag;
    line_t inv_line;

    assign inv_tag  = inv_addr[31 -: TAG_W];
    assign inv_line = inv_addr[31-TAG_W -: LINE_W];

    assign inv_match = inv & (inv_tag == stage1_tag) & (inv_line == stage1_line);

    //////////////////////////////////////////////////////////////////////
    // Snoop lookup on port B
    //////////////////////////////////////////////////////////////////////
    entry_t [WAYS-1:0] b_rdata;
    logic              snoop_valid;
    tag_t              snoop_tag_r;
    line_t             snoop_line_r;
    logic [WAYS-1:0]   snoop_hit;

    always_ff @(posedge clk) begin
        if (rst)
            snoop_valid <= 1'b0;
        else
            snoop_valid <= inv;
        snoop_tag_r  <= inv_tag;
        snoop_line_r <= inv_line;
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++)
            snoop_hit[w] = b_rdata[w].valid & (b_rdata[w].tag == snoop_tag_r);
    end

    assign snoop_write = snoop_valid & (|snoop_hit);

    // Sweep every line once after reset
    line_t rst_line;
    logic  rst_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            rst_line <= '0;
            rst_done <= 1'b0;
        end else if (resetting) begin
            {rst_done, rst_line} <= {1'b0, rst_line} + 1'b1;
        end
    end

    assign resetting = ~rst_done;

    //////////////////////////////////////////////////////////////////////
    // Port A: lookups and writes, snoop clears win
    //////////////////////////////////////////////////////////////////////
    line_t           a_addr;
    logic [WAYS-1:0] a_we;
    entry_t          a_wdata;
    line_t           b_addr;
    entry_t [WAYS-1:0] a_rdata;

    always_comb begin
        if (snoop_write) begin
            a_addr  = snoop_line_r;
            a_we    = snoop_hit;
            a_wdata = '0;
        end else begin
            a_addr  = fill_write ? stage1_line : lookup_line;
            a_we    = fill_write ? fill_way : '0;
            a_wdata = '{valid: fill_valid, tag: stage1_tag};
        end
    end

    assign b_addr = resetting ? rst_line : inv_line;

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (a_we[w])
                tags[w][a_addr] <= a_wdata;
            if (resetting)
                tags[w][b_addr] <= '0;
            a_rdata[w] <= tags[w][a_addr];
            b_rdata[w] <= tags[w][b_addr];
        end
    end

    // One-hot hit against the stage 1 tag
    always_comb begin
        for (int w = 0; w < WAYS; w++)
            hit_way[w] = a_rdata[w].valid & (a_rdata[w].tag == stage1_tag);
    end

    assign hit = |hit_way;

endmodule

// File: testbench/dcache_checker.sv
// Data cache response checker

module dcache_checker
    import dcache_pkg::*;
#(
    parameter int LINES = DEF_LINES
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     ready,
    input  logic     new_request,
    input  ls_req_t  req,
    input  logic     exp_hit,
    input  word_t    exp_word,
    input  logic     data_valid,
    input  word_t    data_out,
    input  logic     mem_request,
    input  mem_req_t mem,
    output int       errors,
    output logic     read_pending
);

    timeunit 1ns;
    timeprecision 100ps;

    int       err_count = 0;
    int       cycle = 0;
    int       rst_cycles = 0;
    logic     seen_ready = 1'b0;
    logic     p_valid = 1'b0;
    logic     p_hit = 1'b0;
    logic     p_mem_seen = 1'b0;
    ls_req_t  p_req = '0;
    word_t    p_word = '0;
    int       p_cycle = 0;
    mem_req_t exp_mem;

    assign errors       = err_count;
    assign read_pending = p_valid & ~p_req.we;

    // All sampling at the falling edge, where DUT outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            rst_cycles = 0;
            seen_ready = 1'b0;
        end else begin
            cycle++;
            ////////////////////////////////////////////////////////////////
            // Reset sweep
            ////////////////////////////////////////////////////////////////
            if (!seen_ready) begin
                if (mem_request || data_valid) begin
                    err_count++;
                    $display("Memory request or read data seen during the reset sweep");
                end
                if (ready) begin
                    seen_ready = 1'b1;
                    if (rst_cycles != LINES) begin
                        err_count++;
                        $display("ERROR ready low cycles got %h expected %h", rst_cycles, LINES);
                    end
                end else begin
                    rst_cycles++;
                end
            end
            ////////////////////////////////////////////////////////////////
            // Memory traffic
            ////////////////////////////////////////////////////////////////
            if (mem_request && !p_mem_seen) begin
                // Writes always go through, reads only on a miss
                if (!p_valid || (p_hit && !p_req.we)) begin
                    err_count++;
                    $display("Memory request raised with no miss or write pending");
                end else begin
                    // Reads fetch the line from word 0, writes go word by word
                    exp_mem.addr  = p_req.we ? p_req.addr[31:2] : {p_req.addr[31:4], 2'b00};
                    exp_mem.wdata = p_req.wdata;
                    exp_mem.wbe   = p_req.be;
                    exp_mem.rnw   = ~p_req.we;
                    exp_mem.rlen  = 5'd3;
                    if (mem.addr != exp_mem.addr) begin
                        err_count++;
                        $display("ERROR mem.addr got %h expected %h", mem.addr, exp_mem.addr);
                    end
                    if (mem.rnw != exp_mem.rnw) begin
                        err_count++;
                        $display("ERROR mem.rnw got %h expected %h", mem.rnw, exp_mem.rnw);
                    end
                    if (p_req.we && (mem.wdata != exp_mem.wdata || mem.wbe != exp_mem.wbe)) begin
                        err_count++;
                        $display("ERROR mem.wdata got %h expected %h, mem.wbe got %h expected %h",
                                 mem.wdata, exp_mem.wdata, mem.wbe, exp_mem.wbe);
                    end
                    if (!p_req.we && mem.rlen != exp_mem.rlen) begin
                        err_count++;
                        $display("ERROR mem.rlen got %h expected %h", mem.rlen, exp_mem.rlen);
                    end
                    p_mem_seen = 1'b1;
                end
            end
            ////////////////////////////////////////////////////////////////
            // Read responses
            ////////////////////////////////////////////////////////////////
            if (data_valid) begin
                if (!p_valid || p_req.we) begin
                    err_count++;
                    $display("Read data returned with no read pending");
                end else begin
                    if (data_out != p_word) begin
                        err_count++;
                        $display("ERROR data_out got %h expected %h", data_out, p_word);
                    end
                    if (p_hit && cycle != p_cycle + 1) begin
                        err_count++;
                        $display("ERROR data_valid latency got %h expected %h",
                                 cycle - p_cycle, 1);
                    end
                    if (!p_hit && !p_mem_seen) begin
                        err_count++;
                        $display("Read expected to miss was answered without a memory request");
                    end
                    p_valid = 1'b0;
                end
            end
            // Acceptance happens at the coming rising edge
            if (new_request && ready) begin
                p_valid    = 1'b1;
                p_req      = req;
                p_hit      = exp_hit;
                p_word     = exp_word;
                p_cycle    = cycle;
                p_mem_seen = 1'b0;
            end
        end
    end

endmodule

// File: testbench/dcache_tb.sv
// Data cache testbench

module dcache_tb
    import dcache_pkg::*;
;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int OP_READ  = 0;
    localparam int OP_WRITE = 1;
    localparam int OP_EXT   = 2;

    typedef struct {
        int    op;
        addr_t addr;
        word_t wdata;
        be_t   be;
        word_t expected;
        logic  hit;
        logic  snoop;
    } entry_t;

    logic     clk, rst, new_request, ready, ack, rvalid, inv;
    logic     data_valid, mem_request, exp_hit, read_pending;
    ls_req_t  req;
    word_t    rdata, data_out, exp_word;
    addr_t    inv_addr;
    mem_req_t mem;
    int       errors;
    int       cycles = 0;
    int       limit;
    int       seed = 32'h6ca2;
    entry_t   table_q[$];
    word_t    mem_model[waddr_t];

    tb_clock clock_i (.clk, .rst);

    dcache_top dut_i (
        .clk, .rst, .new_request, .req, .ack, .rvalid, .rdata, .inv, .inv_addr,
        .ready, .data_valid, .data_out, .mem_request, .mem
    );

    dcache_checker #(.LINES(DEF_LINES)) chk_i (
        .clk, .rst, .ready, .new_request, .req, .exp_hit, .exp_word,
        .data_valid, .data_out, .mem_request, .mem, .errors, .read_pending
    );

    function automatic word_t mem_word(waddr_t a);
        if (mem_model.exists(a))
            return mem_model[a];
        return {2'b00, a} ^ 32'h5a5a0000;
    endfunction

    function automatic word_t merge(word_t old, word_t wdata, be_t be);
        word_t res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                res[8*b +: 8] = wdata[8*b +: 8];
        return res;
    endfunction

    task automatic add_op(int op, addr_t addr, word_t wdata, be_t be, word_t expected,
                          logic hit, logic snoop);
        entry_t e;
        e = '{op, addr, wdata, be, expected, hit, snoop};
        table_q.push_back(e);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory model with random ack delay
    //////////////////////////////////////////////////////////////////////
    initial begin
        mem_req_t m;
        int       delay;
        ack    = 1'b0;
        rvalid = 1'b0;
        rdata  = '0;
        forever begin
            @(negedge clk);
            if (mem_request) begin
                m     = mem;
                delay = 1 + (($random(seed) & 32'h7fff_ffff) % 3);
                repeat (delay) @(posedge clk);
                ack <= 1'b1;
                if (!m.rnw)
                    mem_model[m.addr] = merge(mem_word(m.addr), m.wdata, m.wbe);
                @(posedge clk);
                ack <= 1'b0;
                if (m.rnw) begin
                    for (int i = 0; i <= m.rlen; i++) begin
                        rvalid <= 1'b1;
                        rdata  <= mem_word(m.addr + waddr_t'(i));
                        @(posedge clk);
                    end
                    rvalid <= 1'b0;
                end
            end
        end
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycles++;
        if (cycles >= limit && limit > 0) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        int extra;
        new_request = 1'b0;
        req         = '0;
        inv         = 1'b0;
        inv_addr    = '0;
        exp_hit     = 1'b0;
        exp_word    = '0;
        extra       = 0;
        limit       = 0;
        // Line 0x10 with three tags, then snoop tests at line 0
        add_op(OP_READ,  32'h0000_0108, 0, 4'hf, 32'h5a5a_0042, 0, 0);
        add_op(OP_READ,  32'h0000_0108, 0, 4'hf, 32'h5a5a_0042, 1, 0);
        add_op(OP_WRITE, 32'h0000_0108, 32'h1234_abcd, 4'h3, 0, 1, 0);
        add_op(OP_READ,  32'h0000_0108, 0, 4'hf, 32'h5a5a_abcd, 1, 0);
        add_op(OP_READ,  32'h0000_0508, 0, 4'hf, 32'h5a5a_0142, 0, 0);
        add_op(OP_READ,  32'h0000_0108, 0, 4'hf, 32'h5a5a_abcd, 0, 0);
        add_op(OP_READ,  32'h0000_090c, 0, 4'hf, 32'h5a5a_0243, 0, 0);
        add_op(OP_READ,  32'h0000_0108, 0, 4'hf, 32'h5a5a_abcd, 1, 0);
        add_op(OP_READ,  32'h0000_0508, 0, 4'hf, 32'h5a5a_0142, 0, 0);
        add_op(OP_READ,  32'h0000_2000, 0, 4'hf, 32'h5a5a_0800, 0, 0);
        add_op(OP_READ,  32'h0000_2000, 0, 4'hf, 32'h5a5a_0800, 1, 0);
        add_op(OP_EXT,   32'h0000_2000, 32'hcafe_0001, 4'hf, 0, 0, 1);
        add_op(OP_READ,  32'h0000_2000, 0, 4'hf, 32'hcafe_0001, 0, 0);
        add_op(OP_EXT,   32'h0000_2000, 32'hcafe_0002, 4'hf, 0, 0, 0);
        // Stale copy stays in the cache without a snoop
        add_op(OP_READ,  32'h0000_2000, 0, 4'hf, 32'hcafe_0001, 1, 0);
        add_op(OP_WRITE, 32'h0000_3004, 32'hffee_0000, 4'hc, 0, 0, 0);
        add_op(OP_READ,  32'h0000_3004, 0, 4'hf, 32'hffee_0c01, 0, 0);
        limit = table_q.size() * 40 + DEF_LINES + 100;

        foreach (table_q[i]) begin
            do @(negedge clk); while (!ready || rst);
            @(posedge clk);
            if (table_q[i].op == OP_EXT) begin
                mem_model[table_q[i].addr[31:2]] = table_q[i].wdata;
                if (table_q[i].snoop) begin
                    inv      <= 1'b1;
                    inv_addr <= table_q[i].addr;
                    @(posedge clk);
                    inv <= 1'b0;
                end
                repeat (3) @(posedge clk);
            end else begin
                new_request <= 1'b1;
                req         <= '{addr: table_q[i].addr, wdata: table_q[i].wdata,
                                 be: table_q[i].be, we: table_q[i].op == OP_WRITE};
                exp_hit     <= table_q[i].hit;
                exp_word    <= table_q[i].expected;
                do @(negedge clk); while (!ready);
                @(posedge clk);
                new_request <= 1'b0;
            end
        end

        do @(negedge clk); while (!ready);
        repeat (4) @(negedge clk);
        if (read_pending) begin
            extra++;
            $display("A read was accepted but never returned data");
        end
        $display("Errors: %0d checker, %0d end of run", errors, extra);
        if (errors == 0 && extra == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
// Testbench clock and reset

module tb_clock (
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for five rising edges
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
